// File: design/irq_draw_decode.sv
module irq_draw_decode (
  input  logic [31:0]                        rand_word,
  input  logic [irq_pkg::timing_class_w-1:0] cur_delay_class,
  input  logic [irq_pkg::timing_class_w-1:0] cur_width_class,
  output logic [irq_pkg::delay_w-1:0]        delay_cnt,
  output logic [irq_pkg::cnt_w-1:0]          width_cnt,
  output logic [irq_pkg::irq_w-1:0]          irq_value
);

  import irq_pkg::*;

  logic [delay_w-1:0]     delay_field;
  logic [cnt_w-1:0]       width_field;
  logic [value_sel_w-1:0] value_sel;

  logic [delay_w-1:0] delay_off;
  logic [cnt_w-1:0]   width_off;

  // Split the word into its three fixed fields
  assign delay_field = rand_word[delay_lsb +: delay_w];
  assign width_field = rand_word[width_lsb +: cnt_w];
  assign value_sel   = rand_word[value_lsb +: value_sel_w];

  // Gap length
  always_comb begin
    delay_off = delay_field & delay_mask[cur_delay_class];
    delay_cnt = delay_base[cur_delay_class] + delay_off;
  end

  // Pulse length
  always_comb begin
    width_off = width_field & width_mask[cur_width_class];
    width_cnt = width_base[cur_width_class] + width_off;
  end

  // Weighted pick of which lines to raise
  always_comb begin
    if (value_sel < value_both_lim) begin
      irq_value = irq_both;
    end else if (value_sel < value_mach_lim) begin
      irq_value = irq_mach;
    end else begin
      irq_value = irq_sup;
    end
  end

endmodule

// File: design/irq_pkg.sv
package irq_pkg;

  // Timing class codes, shared by delay and width
  localparam int timing_class_w = 2;
  localparam logic [timing_class_w-1:0] class_very_short = 2'd0;
  localparam logic [timing_class_w-1:0] class_short      = 2'd1;
  localparam logic [timing_class_w-1:0] class_normal     = 2'd2;
  localparam logic [timing_class_w-1:0] class_long       = 2'd3;

  // Counter widths
  localparam int delay_w = 8;
  localparam int cnt_w   = 6;
  localparam int count_w = 16;
  localparam int irq_w   = 2;

  // Gap ranges are base .. base + mask
  localparam logic [delay_w-1:0] delay_base [4] = '{
    class_very_short: 8'd1,
    class_short:      8'd16,
    class_normal:     8'd48,
    class_long:       8'd112
  };
  localparam logic [delay_w-1:0] delay_mask [4] = '{
    class_very_short: 8'd15,
    class_short:      8'd31,
    class_normal:     8'd63,
    class_long:       8'd127
  };

  // Pulse length ranges, same scheme
  localparam logic [cnt_w-1:0] width_base [4] = '{
    class_very_short: 6'd2,
    class_short:      6'd4,
    class_normal:     6'd8,
    class_long:       6'd16
  };
  localparam logic [cnt_w-1:0] width_mask [4] = '{
    class_very_short: 6'd3,
    class_short:      6'd7,
    class_normal:     6'd15,
    class_long:       6'd31
  };

  // Field layout of one random word
  localparam int delay_lsb   = 0;
  localparam int width_lsb   = 8;
  localparam int value_lsb   = 16;
  localparam int value_sel_w = 7;

  // Selector limits, out of 128, for roughly 10/30/60 percent
  localparam logic [value_sel_w-1:0] value_both_lim = 7'd13;
  localparam logic [value_sel_w-1:0] value_mach_lim = 7'd51;

  // Line values, bit 1 machine and bit 0 supervisor
  localparam logic [irq_w-1:0] irq_both = 2'b11;
  localparam logic [irq_w-1:0] irq_mach = 2'b10;
  localparam logic [irq_w-1:0] irq_sup  = 2'b01;

  // Sequencer state codes
  localparam int state_w = 2;
  localparam logic [state_w-1:0] st_idle  = 2'd0;
  localparam logic [state_w-1:0] st_delay = 2'd1;
  localparam logic [state_w-1:0] st_pulse = 2'd2;

  localparam logic [31:0] rng_seed = 32'h2545F491;

endpackage

// File: design/irq_rng.sv
module irq_rng (
  input  logic        clk_i,
  input  logic        rst,
  input  logic        draw_step,
  output logic [31:0] rand_word
);

  import irq_pkg::*;

  logic [31:0] state_q;
  logic [31:0] mix_a;
  logic [31:0] mix_b;
  logic [31:0] state_next;

  // Xorshift32 with shifts 13, 17, 5
  always_comb begin
    mix_a      = state_q ^ (state_q << 13);
    mix_b      = mix_a ^ (mix_a >> 17);
    state_next = mix_b ^ (mix_b << 5);
  end

  // Only moves on a draw, so the sequence depends on draws alone
  always_ff @(posedge clk_i) begin
    if (rst) begin
      state_q <= rng_seed;
    end else if (draw_step) begin
      state_q <= state_next;
    end
  end

  // Consumer sees the word before the step
  assign rand_word = state_q;

endmodule

// File: design/irq_sequencer.sv
module irq_sequencer (
  input  logic                               clk_i,
  input  logic                               rst,
  input  logic                               begin_drive,
  input  logic                               end_drive,
  input  logic [irq_pkg::timing_class_w-1:0] delay_class,
  input  logic [irq_pkg::timing_class_w-1:0] width_class,
  input  logic [irq_pkg::delay_w-1:0]        delay_cnt,
  input  logic [irq_pkg::cnt_w-1:0]          width_cnt,
  input  logic [irq_pkg::irq_w-1:0]          irq_value,
  output logic                               draw_step,
  output logic [irq_pkg::timing_class_w-1:0] cur_delay_class,
  output logic [irq_pkg::timing_class_w-1:0] cur_width_class,
  output logic [irq_pkg::irq_w-1:0]          irq_line,
  output logic [irq_pkg::count_w-1:0]        irq_count,
  output logic                               driving
);

  import irq_pkg::*;

  logic [state_w-1:0] state_q;
  logic [delay_w-1:0] gap_left_q;
  logic [cnt_w-1:0]   pulse_left_q;

  // Width and value of the pulse that follows the current gap
  logic [cnt_w-1:0] width_q;
  logic [irq_w-1:0] value_q;

  logic [timing_class_w-1:0] delay_class_q;
  logic [timing_class_w-1:0] width_class_q;

  logic start_drive;
  logic gap_done;
  logic pulse_last;
  logic pulse_done;

  assign start_drive = (state_q == st_idle) && begin_drive && !end_drive;
  assign gap_done    = (state_q == st_delay) && (gap_left_q == delay_w'(1));
  assign pulse_last  = (state_q == st_pulse) && (pulse_left_q == cnt_w'(1));

  // A pulse cut by end_drive does not count as done
  assign pulse_done = pulse_last && !end_drive;

  // One draw on start and one at the end of every full pulse
  assign draw_step = start_drive || pulse_done;

  assign driving = (state_q != st_idle);

  // In idle the live classes feed the decoder so the first draw sees them
  assign cur_delay_class = (state_q == st_idle) ? delay_class : delay_class_q;
  assign cur_width_class = (state_q == st_idle) ? width_class : width_class_q;

  always_ff @(posedge clk_i) begin
    if (start_drive) begin
      delay_class_q <= delay_class;
      width_class_q <= width_class;
    end
  end

  // Capture the rest of the drawn word for the coming pulse
  always_ff @(posedge clk_i) begin
    if (draw_step) begin
      width_q <= width_cnt;
      value_q <= irq_value;
    end
  end

  // Main FSM, end_drive wins in every state
  always_ff @(posedge clk_i) begin
    if (rst) begin
      state_q      <= st_idle;
      gap_left_q   <= '0;
      pulse_left_q <= '0;
      irq_line     <= '0;
    end else if (end_drive) begin
      state_q  <= st_idle;
      irq_line <= '0;
    end else begin
      case (state_q)
        st_idle: begin
          if (begin_drive) begin
            state_q    <= st_delay;
            gap_left_q <= delay_cnt;
          end
        end

        st_delay: begin
          if (gap_done) begin
            state_q      <= st_pulse;
            pulse_left_q <= width_q;
            irq_line     <= value_q;
          end else begin
            gap_left_q <= gap_left_q - delay_w'(1);
          end
        end

        st_pulse: begin
          if (pulse_last) begin
            // Back to a fresh gap from the word drawn this cycle
            state_q    <= st_delay;
            gap_left_q <= delay_cnt;
            irq_line   <= '0;
          end else begin
            pulse_left_q <= pulse_left_q - cnt_w'(1);
          end
        end

        default: begin
          state_q  <= st_idle;
          irq_line <= '0;
        end
      endcase
    end
  end

  // Completed pulse counter, kept across begin/end
  always_ff @(posedge clk_i) begin
    if (rst) begin
      irq_count <= '0;
    end else if (pulse_done) begin
      irq_count <= irq_count + count_w'(1);
    end
  end

endmodule

// File: design/irq_stim_top.sv
module irq_stim_top (
  input  logic                               clk_i,
  input  logic                               rst,
  input  logic                               begin_drive,
  input  logic                               end_drive,
  input  logic [irq_pkg::timing_class_w-1:0] delay_class,
  input  logic [irq_pkg::timing_class_w-1:0] width_class,
  output logic [irq_pkg::irq_w-1:0]          irq_line,
  output logic [irq_pkg::count_w-1:0]        irq_count,
  output logic                               driving
);

  import irq_pkg::*;

  logic        draw_step;
  logic [31:0] rand_word;

  logic [timing_class_w-1:0] cur_delay_class;
  logic [timing_class_w-1:0] cur_width_class;

  // Decoded draw, valid every cycle
  logic [delay_w-1:0] delay_cnt;
  logic [cnt_w-1:0]   width_cnt;
  logic [irq_w-1:0]   irq_value;

  irq_rng u_rng (
    .clk_i     (clk_i),
    .rst       (rst),
    .draw_step (draw_step),
    .rand_word (rand_word)
  );

  irq_draw_decode u_decode (
    .rand_word       (rand_word),
    .cur_delay_class (cur_delay_class),
    .cur_width_class (cur_width_class),
    .delay_cnt       (delay_cnt),
    .width_cnt       (width_cnt),
    .irq_value       (irq_value)
  );

  irq_sequencer u_seq (
    .clk_i           (clk_i),
    .rst             (rst),
    .begin_drive     (begin_drive),
    .end_drive       (end_drive),
    .delay_class     (delay_class),
    .width_class     (width_class),
    .delay_cnt       (delay_cnt),
    .width_cnt       (width_cnt),
    .irq_value       (irq_value),
    .draw_step       (draw_step),
    .cur_delay_class (cur_delay_class),
    .cur_width_class (cur_width_class),
    .irq_line        (irq_line),
    .irq_count       (irq_count),
    .driving         (driving)
  );

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the interrupt stimulus testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/100ps --top-module irq_stim_tb \
  -f sim.f -o irq_sim || { echo "Build failed"; exit 1; }
out=$(./obj_dir/irq_sim)
echo "$out"
echo "$out" | grep -q "SIMULATION PASSED" && echo "Run passed" || { echo "Run failed"; exit 1; }

// File: sim.f
design/irq_pkg.sv
design/irq_rng.sv
design/irq_draw_decode.sv
design/irq_sequencer.sv
design/irq_stim_top.sv
test/tb_clock.sv
test/irq_stim_tb.sv

// File: test/irq_patterns.txt
# name delay_class width_class pulses
# classes 0 very short, 1 short, 2 normal, 3 long
vs_vs       0 0 8
vs_short    0 1 6
short_vs    1 0 6
short_short 1 1 5
normal_vs   2 0 5
vs_normal   0 2 6
normal_nrm  2 2 4
long_vs     3 0 3
vs_long     0 3 5
short_long  1 3 4
long_long   3 3 3
normal_sh   2 1 4
vs_vs_b     0 0 10
short_nrm   1 2 5
long_short  3 1 3
vs_vs_c     0 0 8
nrm_long    2 3 3
vs_short_b  0 1 6

// File: test/irq_stim_tb.sv
module irq_stim_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import irq_pkg::*;

  // Lowest and highest cycle count of each class
  localparam int delay_lo [4] = '{1, 16, 48, 112};
  localparam int delay_hi [4] = '{16, 47, 111, 239};
  localparam int width_lo [4] = '{2, 4, 8, 16};
  localparam int width_hi [4] = '{5, 11, 23, 47};

  localparam int gap_limit        = 260;
  localparam int pulse_limit      = 60;
  localparam int cycles_per_pulse = 239 + 47 + 2;

  logic                      clk_i;
  logic                      rst;
  logic                      begin_drive;
  logic                      end_drive;
  logic [timing_class_w-1:0] delay_class;
  logic [timing_class_w-1:0] width_class;
  logic [irq_w-1:0]          irq_line;
  logic [count_w-1:0]        irq_count;
  logic                      driving;

  string       test_name;
  string       pat_name [$];
  int          pat_dclass [$];
  int          pat_wclass [$];
  int          pat_pulses [$];
  logic [31:0] model_state;
  logic [31:0] rnd_state;
  int          exp_count;
  int          error_count;
  int          pulse_checks;
  int          budget_cycles;
  logic [3:0]  seen_val;

  tb_clock u_clock (
    .clk_i (clk_i),
    .rst   (rst)
  );

  irq_stim_top DUT (
    .clk_i       (clk_i),
    .rst         (rst),
    .begin_drive (begin_drive),
    .end_drive   (end_drive),
    .delay_class (delay_class),
    .width_class (width_class),
    .irq_line    (irq_line),
    .irq_count   (irq_count),
    .driving     (driving)
  );

  function automatic logic [31:0] next_xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Stimulus randomness kept apart from the DUT generator
  function automatic logic [31:0] rand_next();
    rnd_state = next_xorshift(rnd_state);
    return rnd_state;
  endfunction

  task automatic log_error(input string msg);
    error_count++;
    $display("Error in %s: %s", test_name, msg);
  endtask

  task automatic flag_mismatch(input string what, input int expected, input int actual);
    error_count++;
    $display("Fail %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
  endtask

  task automatic range_violation(input string what, input int lo, input int hi,
                                 input int actual);
    error_count++;
    $display("Fail %s %s range: expected %0d to %0d, actual %0d",
             test_name, what, lo, hi, actual);
  endtask

  task automatic finish_run();
    $display("Done: %0d pulses checked, %0d errors", pulse_checks, error_count);
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  endtask

  // Outputs are sampled and inputs driven 10 ns after each rising edge
  task automatic step();
    @(posedge clk_i);
    #10;
  endtask

  // Gap, width and line value that the next draw should produce
  task automatic draw_model(input logic [1:0] dcls, input logic [1:0] wcls,
                            output int d, output int w, output logic [1:0] v);
    int sel;
    d = delay_lo[dcls] + (int'(model_state[7:0]) & (delay_hi[dcls] - delay_lo[dcls]));
    w = width_lo[wcls] + (int'(model_state[13:8]) & (width_hi[wcls] - width_lo[wcls]));
    sel = int'(model_state[22:16]);
    if (sel < 13) begin
      v = 2'b11;
    end else if (sel < 51) begin
      v = 2'b10;
    end else begin
      v = 2'b01;
    end
    model_state = next_xorshift(model_state);
  endtask

  task automatic load_patterns();
    int    fd;
    int    code;
    int    dc;
    int    wc;
    int    np;
    string tok;
    string rest;
    logic  more;
    fd = $fopen("test/irq_patterns.txt", "r");
    if (fd == 0) begin
      log_error("cannot open test/irq_patterns.txt");
      return;
    end
    more = 1'b1;
    while (more) begin
      code = $fscanf(fd, "%s", tok);
      if (code != 1) begin
        more = 1'b0;
      end else if (tok.getc(0) == "#") begin
        code = $fgets(rest, fd);
      end else begin
        code = $fscanf(fd, "%d %d %d", dc, wc, np);
        if (code != 3 || np < 1) begin
          log_error($sformatf("pattern line %s is incomplete", tok));
          more = 1'b0;
        end else begin
          pat_name.push_back(tok);
          pat_dclass.push_back(dc);
          pat_wclass.push_back(wc);
          pat_pulses.push_back(np);
        end
      end
    end
    $fclose(fd);
  endtask

  // Counts edges until the line rises and releases begin_drive on the first one
  task automatic measure_gap(output int n);
    step();
    begin_drive = 1'b0;
    n = 1;
    while (irq_line == 2'b00 && n < gap_limit) begin
      step();
      n++;
    end
    if (irq_line == 2'b00) begin
      log_error($sformatf("no pulse within %0d cycles", gap_limit));
    end
  endtask

  // The count only moves on the edge that ends the pulse
  task automatic measure_pulse(output int n);
    logic [1:0] held;
    held = irq_line;
    n = 0;
    while (irq_line != 2'b00 && n < pulse_limit) begin
      if (int'(irq_count) != exp_count) begin
        flag_mismatch("count during pulse", exp_count, int'(irq_count));
      end
      if (driving != 1'b1) begin
        log_error("driving low during a pulse");
      end
      step();
      n++;
      if (irq_line != 2'b00 && irq_line != held) begin
        flag_mismatch("held value", int'(held), int'(irq_line));
      end
    end
    if (irq_line != 2'b00) begin
      log_error("pulse did not end");
    end
  endtask

  task automatic run_test(input int t);
    logic [1:0]  dcls;
    logic [1:0]  wcls;
    logic [1:0]  v;
    logic [31:0] r;
    int          idle;
    int          d;
    int          w;
    int          gap;
    int          len;
    int          k;
    test_name = pat_name[t];
    dcls = 2'(pat_dclass[t]);
    wcls = 2'(pat_wclass[t]);
    idle = 1 + int'(rand_next() % 32'd8);
    repeat (idle) begin
      step();
      if (irq_line != 2'b00 || driving != 1'b0) begin
        log_error("line or driving active while idle");
      end
    end
    delay_class = dcls;
    width_class = wcls;
    begin_drive = 1'b1;
    step();
    // Begin stays high one more cycle and the classes move while driving
    r = rand_next();
    delay_class = r[1:0];
    width_class = r[3:2];
    if (driving != 1'b1) begin
      log_error("driving not raised after begin_drive");
    end
    for (int p = 0; p < pat_pulses[t]; p++) begin
      draw_model(dcls, wcls, d, w, v);
      measure_gap(gap);
      if (gap != d) begin
        flag_mismatch("gap", d, gap);
      end
      if (gap < delay_lo[dcls] || gap > delay_hi[dcls]) begin
        range_violation("gap", delay_lo[dcls], delay_hi[dcls], gap);
      end
      if (irq_line != v) begin
        flag_mismatch("value", int'(v), int'(irq_line));
      end
      seen_val[irq_line] = 1'b1;
      measure_pulse(len);
      if (len != w) begin
        flag_mismatch("width", w, len);
      end
      if (len < width_lo[wcls] || len > width_hi[wcls]) begin
        range_violation("width", width_lo[wcls], width_hi[wcls], len);
      end
      exp_count++;
      pulse_checks++;
      if (int'(irq_count) != exp_count) begin
        flag_mismatch("count", exp_count, int'(irq_count));
      end
    end
    // The word for the following gap is already drawn
    draw_model(dcls, wcls, d, w, v);
    if (rand_next() % 32'd2 == 32'd0) begin
      k = int'(rand_next() % 32'(d));
      repeat (k) begin
        step();
      end
    end else begin
      measure_gap(gap);
      if (gap != d) begin
        flag_mismatch("gap before cut", d, gap);
      end
      if (irq_line != v) begin
        flag_mismatch("value before cut", int'(v), int'(irq_line));
      end
      k = 1 + int'(rand_next() % 32'(w - 1));
      repeat (k - 1) begin
        step();
      end
    end
    end_drive = 1'b1;
    step();
    end_drive = 1'b0;
    if (irq_line != 2'b00) begin
      flag_mismatch("line after end", 0, int'(irq_line));
    end
    if (driving != 1'b0) begin
      flag_mismatch("driving after end", 0, int'(driving));
    end
    if (int'(irq_count) != exp_count) begin
      flag_mismatch("count after end", exp_count, int'(irq_count));
    end
  endtask

  initial begin
    begin_drive   = 1'b0;
    end_drive     = 1'b0;
    delay_class   = '0;
    width_class   = '0;
    model_state   = rng_seed;
    rnd_state     = 32'd79;
    exp_count     = 0;
    error_count   = 0;
    pulse_checks  = 0;
    seen_val      = '0;
    test_name     = "setup";
    load_patterns();
    // Checked pulses plus the cut one and the reset and idle stretches
    budget_cycles = 128;
    foreach (pat_pulses[i]) begin
      budget_cycles += (pat_pulses[i] + 2) * cycles_per_pulse + 8;
    end
    test_name = "reset";
    wait (rst == 1'b0);
    repeat (20) begin
      step();
      if (irq_line != 2'b00 || driving != 1'b0 || irq_count != '0) begin
        log_error("outputs not at rest after reset");
      end
    end
    for (int t = 0; t < pat_name.size(); t++) begin
      run_test(t);
    end
    test_name = "coverage";
    if (!seen_val[1]) begin
      log_error("line value 01 never seen");
    end
    if (!seen_val[2]) begin
      log_error("line value 10 never seen");
    end
    if (!seen_val[3]) begin
      log_error("line value 11 never seen");
    end
    finish_run();
  end

  initial begin
    wait (budget_cycles != 0);
    repeat (budget_cycles) begin
      @(posedge clk_i);
    end
    log_error($sformatf("timeout, run still going after %0d cycles", budget_cycles));
    finish_run();
  end

endmodule

// File: test/tb_clock.sv
module tb_clock (
  output logic clk_i,
  output logic rst
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int half_period  = 50;
  localparam int reset_cycles = 8;

  // 100 ns free running clock
  initial begin
    clk_i = 1'b0;
    forever begin
      #half_period clk_i = ~clk_i;
    end
  end

  // Reset drops shortly after an edge, like every other input
  initial begin
    rst = 1'b1;
    repeat (reset_cycles) begin
      @(posedge clk_i);
    end
    #10;
    rst = 1'b0;
  end

endmodule
